// File: files.f
proc_pkg.sv
bypass_if.sv
alu.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
mem_wb_stage.sv
processor.sv
tb_processor.sv

// File: run.sh
#!/bin/sh
set -e

verilator --binary -j 0 --top-module tb_processor -f files.f -o tb_processor

output=$(./obj_dir/tb_processor 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'STATUS: PASS'; then
    exit 0
fi
exit 1

// File: tb_processor.sv
module tb_processor;
    import proc_pkg::*;

    localparam int       PROG_LEN   = 200;
    localparam int       IMEM_WORDS = 1024;
    localparam int       DMEM_WORDS = 256;
    localparam int       MAX_CYCLES = 2000;
    localparam word_t    START_PC   = 32'd16;
    localparam reg_idx_t BASE_REG   = 5'd6;   // Only ever holds a small data address
    localparam reg_idx_t JUMP_REG   = 5'd7;   // Only ever holds a jr target

    // Small register pool so that dependences are frequent
    localparam reg_idx_t REG_POOL [8] = '{5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd0, 5'd31, 5'd2};
    localparam alu_op_t  ALU_POOL [6] = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLL, ALU_SRA};

    logic     clock;
    logic     rst_n;
    word_t    address_imem;
    word_t    q_imem;
    word_t    address_dmem;
    word_t    data;
    logic     wren;
    word_t    q_dmem;
    logic     ctrl_writeEnable;
    reg_idx_t ctrl_writeReg;
    reg_idx_t ctrl_readRegA;
    reg_idx_t ctrl_readRegB;
    word_t    data_writeReg;
    word_t    data_readRegA;
    word_t    data_readRegB;

    word_t imem [IMEM_WORDS];
    word_t dmem [DMEM_WORDS] = '{default: '0};
    word_t regs [32] = '{default: '0};
    word_t model_regs [32];
    word_t model_mem [DMEM_WORDS];

    insn_t    prog [$];
    bit       is_ctrl [$];     // Target still to be filled in
    bit       no_land [$];     // A jr whose setup could be skipped
    reg_idx_t exp_reg_idx [$];
    word_t    exp_reg_val [$];
    word_t    exp_mem_addr [$];
    word_t    exp_mem_val [$];
    int       reg_pos = 0;
    int       mem_pos = 0;

    processor #(
        .RESET_PC (START_PC)
    ) i_processor (
        .clock            (clock),
        .rst_n            (rst_n),
        .address_imem     (address_imem),
        .q_imem           (q_imem),
        .address_dmem     (address_dmem),
        .data             (data),
        .wren             (wren),
        .q_dmem           (q_dmem),
        .ctrl_writeEnable (ctrl_writeEnable),
        .ctrl_writeReg    (ctrl_writeReg),
        .ctrl_readRegA    (ctrl_readRegA),
        .ctrl_readRegB    (ctrl_readRegB),
        .data_writeReg    (data_writeReg),
        .data_readRegA    (data_readRegA),
        .data_readRegB    (data_readRegB)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic word_t dmem_fill(int k);
        return (word_t'(k) * 32'h9E3779B1) ^ 32'h0BADF00D;
    endfunction

    // External memories and write-through register file
    assign q_imem = imem[address_imem[9:0]];
    assign q_dmem = dmem[address_dmem[7:0]];
    assign data_readRegA = (ctrl_writeEnable && ctrl_readRegA != '0 &&
                            ctrl_writeReg == ctrl_readRegA) ? data_writeReg : regs[ctrl_readRegA];
    assign data_readRegB = (ctrl_writeEnable && ctrl_readRegB != '0 &&
                            ctrl_writeReg == ctrl_readRegB) ? data_writeReg : regs[ctrl_readRegB];

    always @(posedge clock) begin
        if (!rst_n) begin
            for (int k = 0; k < 32; k++) begin
                regs[5'(k)] <= '0;
            end
            for (int k = 0; k < DMEM_WORDS; k++) begin
                dmem[8'(k)] <= dmem_fill(k);
            end
        end else begin
            if (ctrl_writeEnable && ctrl_writeReg != '0) begin
                regs[ctrl_writeReg] <= data_writeReg;
            end
            if (wren) begin
                dmem[address_dmem[7:0]] <= data;
            end
        end
    end

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(string name, word_t got, word_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    function automatic reg_idx_t pick_reg();
        return REG_POOL[3'($urandom)];
    endfunction

    function automatic alu_op_t pick_alu();
        return ALU_POOL[3'($urandom % 6)];
    endfunction

    function automatic insn_t make_r(reg_idx_t rd, reg_idx_t rs, reg_idx_t rt,
                                     logic [4:0] shamt, alu_op_t aop);
        insn_t w;
        w         = '0;
        w.r.rd    = rd;
        w.r.rs    = rs;
        w.r.rt    = rt;
        w.r.shamt = shamt;
        w.r.aluop = aop;
        return w;
    endfunction

    function automatic insn_t make_i(opcode_t op, reg_idx_t rd, reg_idx_t rs, logic [16:0] imm);
        insn_t w;
        w          = '0;
        w.i.opcode = op;
        w.i.rd     = rd;
        w.i.rs     = rs;
        w.i.imm    = imm;
        return w;
    endfunction

    function automatic insn_t make_j(opcode_t op, logic [26:0] target);
        insn_t w;
        w           = '0;
        w.ji.opcode = op;
        w.ji.target = target;
        return w;
    endfunction

    task automatic emit(insn_t w, bit ctrl, bit no_target);
        prog.push_back(w);
        is_ctrl.push_back(ctrl);
        no_land.push_back(no_target);
    endtask

    task automatic emit_alu();
        if ($urandom % 3 == 0) begin
            emit(make_i(OP_ADDI, pick_reg(), pick_reg(), 17'($urandom % 64) - 17'd32),
                 1'b0, 1'b0);
        end else begin
            emit(make_r(pick_reg(), pick_reg(), pick_reg(), 5'($urandom), pick_alu()), 1'b0, 1'b0);
        end
    endtask

    // Forward target inside the program and never onto a jr
    function automatic int pick_target(int from);
        int t;
        t = from + 1 + int'($urandom % 8);
        if (t > PROG_LEN - 1) begin
            t = PROG_LEN - 1;
        end
        while (no_land[t]) begin
            t++;
        end
        return t;
    endfunction

    task automatic gen_program();
        int       kind;
        int       n;
        opcode_t  op;
        reg_idx_t rd;
        insn_t    w;
        while (prog.size() < PROG_LEN - 1) begin
            kind = int'($urandom % 10);
            if (kind < 4 || prog.size() > PROG_LEN - 5) begin
                emit_alu();
            end else begin
                case (kind)
                    4, 5: begin
                        emit(make_i(OP_ADDI, BASE_REG, '0, 17'(16 + $urandom % 64)), 1'b0, 1'b0);
                        n = 1 + int'($urandom % 3);
                        repeat (n) begin
                            op = ($urandom % 2 == 0) ? OP_LW : OP_SW;
                            emit(make_i(op, pick_reg(), BASE_REG, 17'($urandom % 16) - 17'd8),
                                 1'b0, 1'b0);
                        end
                    end
                    6: begin
                        op = ($urandom % 2 == 0) ? OP_BNE : OP_BLT;
                        emit(make_i(op, pick_reg(), pick_reg(), '0), 1'b1, 1'b0);
                    end
                    7: begin
                        op = ($urandom % 2 == 0) ? OP_J : OP_JAL;
                        emit(make_j(op, '0), 1'b1, 1'b0);
                    end
                    8: begin
                        emit(make_i(OP_ADDI, JUMP_REG, '0, '0), 1'b1, 1'b0);
                        emit(make_i(OP_JR, JUMP_REG, '0, '0), 1'b0, 1'b1);
                    end
                    default: begin
                        rd = pick_reg();   // Load then immediate use
                        emit(make_i(OP_ADDI, BASE_REG, '0, 17'(16 + $urandom % 64)), 1'b0, 1'b0);
                        emit(make_i(OP_LW, rd, BASE_REG, 17'($urandom % 8)), 1'b0, 1'b0);
                        emit(make_r(pick_reg(), rd, pick_reg(), 5'($urandom), pick_alu()),
                             1'b0, 1'b0);
                    end
                endcase
            end
        end
        emit_alu();
        for (int i = 0; i < PROG_LEN; i++) begin
            if (is_ctrl[i]) begin
                w = prog[i];
                case (w.r.opcode)
                    OP_ADDI: begin
                        w.i.imm = 17'(START_PC + word_t'(pick_target(i + 1)));  // Past its jr
                    end
                    OP_BNE, OP_BLT: begin
                        w.i.imm = 17'(pick_target(i) - (i + 1));
                    end
                    default: begin
                        w.ji.target = 27'(START_PC + word_t'(pick_target(i)));
                    end
                endcase
                prog[i] = w;
            end
        end
    endtask

    function automatic word_t expected_alu(alu_op_t aop, word_t a, word_t b, logic [4:0] sh);
        case (aop)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_SLL: return a << sh;
            // Copies of the sign bit fill the vacated top bits
            ALU_SRA: return (a >> sh) | ({XLEN{a[XLEN-1]}} & ~({XLEN{1'b1}} >> sh));
            default: return '0;
        endcase
    endfunction

    task automatic model_write(reg_idx_t r, word_t v);
        if (r != '0) begin
            model_regs[r] = v;
            exp_reg_idx.push_back(r);
            exp_reg_val.push_back(v);
        end
    endtask

    // Instruction-level reference run
    task automatic run_model();
        int    idx;
        insn_t w;
        word_t a;
        word_t d;
        word_t imm;
        word_t pc1;
        word_t nxt;
        word_t addr;
        for (int k = 0; k < 32; k++) begin
            model_regs[5'(k)] = '0;
        end
        for (int k = 0; k < DMEM_WORDS; k++) begin
            model_mem[8'(k)] = dmem_fill(k);
        end
        idx = 0;
        while (idx < PROG_LEN) begin
            w    = prog[idx];
            a    = model_regs[w.r.rs];
            d    = model_regs[w.r.rd];
            imm  = {{15{w.i.imm[16]}}, w.i.imm};
            pc1  = START_PC + word_t'(idx) + 32'd1;
            nxt  = pc1;
            addr = a + imm;
            case (w.r.opcode)
                OP_RTYPE: model_write(w.r.rd, expected_alu(w.r.aluop, a, model_regs[w.r.rt],
                                                           w.r.shamt));
                OP_ADDI:  model_write(w.i.rd, addr);
                OP_LW:    model_write(w.i.rd, model_mem[addr[7:0]]);
                OP_SW: begin
                    model_mem[addr[7:0]] = d;
                    exp_mem_addr.push_back(addr);
                    exp_mem_val.push_back(d);
                end
                OP_J:     nxt = {5'b0, w.ji.target};
                OP_JAL: begin
                    model_write(LINK_REG, pc1);
                    nxt = {5'b0, w.ji.target};
                end
                OP_JR:    nxt = d;
                OP_BNE:   nxt = (a != d) ? pc1 + imm : pc1;
                OP_BLT:   nxt = ($signed(d) < $signed(a)) ? pc1 + imm : pc1;
                default: begin
                end
            endcase
            idx = int'(nxt - START_PC);
        end
    endtask

    // Write monitor sampled mid-cycle
    always @(negedge clock) begin
        if (rst_n && ctrl_writeEnable) begin
            if (reg_pos >= exp_reg_idx.size()) begin
                stop_on_error("DUT wrote a register after the last write the model expects");
            end else begin
                check_value("ctrl_writeReg", word_t'(ctrl_writeReg),
                            word_t'(exp_reg_idx[reg_pos]));
                check_value("data_writeReg", data_writeReg, exp_reg_val[reg_pos]);
                reg_pos++;
            end
        end
        if (rst_n && wren) begin
            if (mem_pos >= exp_mem_addr.size()) begin
                stop_on_error("DUT wrote data memory after the last write the model expects");
            end else begin
                check_value("address_dmem", address_dmem, exp_mem_addr[mem_pos]);
                check_value("data", data, exp_mem_val[mem_pos]);
                mem_pos++;
            end
        end
    end

    initial begin
        int cycles;
        rst_n = 1'b0;
        void'($urandom(32'h58f01b8f));
        gen_program();
        for (int k = 0; k < IMEM_WORDS; k++) begin
            imem[10'(k)] = NOP_INSN;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            imem[10'(START_PC + word_t'(i))] = prog[i];
        end
        run_model();

        repeat (10) @(posedge clock);
        #1;
        check_value("address_imem", address_imem, START_PC);
        check_value("wren", word_t'(wren), '0);
        check_value("ctrl_writeEnable", word_t'(ctrl_writeEnable), '0);
        rst_n = 1'b1;

        cycles = 0;
        while ((reg_pos < exp_reg_idx.size() || mem_pos < exp_mem_addr.size()) &&
               cycles < MAX_CYCLES) begin
            @(posedge clock);
            cycles++;
        end
        if (reg_pos < exp_reg_idx.size() || mem_pos < exp_mem_addr.size()) begin
            stop_on_error("Timeout: the program did not finish within 2000 cycles");
        end else begin
            // Trailing NOPs must not write anything while the pipeline drains
            repeat (8) @(posedge clock);
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

// File: processor.sv
module processor #(
    parameter proc_pkg::word_t RESET_PC = '0
) (
    input  logic               clock,
    input  logic               rst_n,
    output proc_pkg::word_t    address_imem,
    input  proc_pkg::word_t    q_imem,
    output proc_pkg::word_t    address_dmem,
    output proc_pkg::word_t    data,
    output logic               wren,
    input  proc_pkg::word_t    q_dmem,
    output logic               ctrl_writeEnable,
    output proc_pkg::reg_idx_t ctrl_writeReg,
    output proc_pkg::reg_idx_t ctrl_readRegA,
    output proc_pkg::reg_idx_t ctrl_readRegB,
    output proc_pkg::word_t    data_writeReg,
    input  proc_pkg::word_t    data_readRegA,
    input  proc_pkg::word_t    data_readRegB
);
    import proc_pkg::*;

    logic     stall;
    logic     redirect;
    word_t    redirect_pc;
    insn_t    fd_insn;
    word_t    fd_pc_plus1;
    insn_t    de_insn;
    word_t    de_pc_plus1;
    word_t    de_a;
    word_t    de_b;
    word_t    de_imm;
    reg_idx_t de_src_a;
    reg_idx_t de_src_b;
    insn_t    em_insn;
    word_t    em_result;
    word_t    em_addr;
    word_t    em_store;

    bypass_if byp ();

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) i_fetch (
        .clock       (clock),
        .rst_n       (rst_n),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_data   (q_imem),
        .pc          (address_imem),
        .fd_pc_plus1 (fd_pc_plus1),
        .fd_insn     (fd_insn)
    );

    decode_stage i_decode (
        .clock       (clock),
        .rst_n       (rst_n),
        .redirect    (redirect),
        .fd_insn     (fd_insn),
        .fd_pc_plus1 (fd_pc_plus1),
        .reg_a_data  (data_readRegA),
        .reg_b_data  (data_readRegB),
        .read_reg_a  (ctrl_readRegA),
        .read_reg_b  (ctrl_readRegB),
        .stall       (stall),
        .de_insn     (de_insn),
        .de_pc_plus1 (de_pc_plus1),
        .de_a        (de_a),
        .de_b        (de_b),
        .de_imm      (de_imm),
        .de_src_a    (de_src_a),
        .de_src_b    (de_src_b)
    );

    execute_stage i_execute (
        .clock       (clock),
        .rst_n       (rst_n),
        .de_insn     (de_insn),
        .de_pc_plus1 (de_pc_plus1),
        .de_a        (de_a),
        .de_b        (de_b),
        .de_imm      (de_imm),
        .de_src_a    (de_src_a),
        .de_src_b    (de_src_b),
        .byp         (byp.consumer),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .em_insn     (em_insn),
        .em_result   (em_result),
        .em_addr     (em_addr),
        .em_store    (em_store)
    );

    mem_wb_stage i_mem_wb (
        .clock     (clock),
        .rst_n     (rst_n),
        .em_insn   (em_insn),
        .em_result (em_result),
        .em_addr   (em_addr),
        .em_store  (em_store),
        .dmem_q    (q_dmem),
        .byp       (byp.producer),
        .dmem_addr (address_dmem),
        .dmem_data (data),
        .dmem_wren (wren),
        .reg_we    (ctrl_writeEnable),
        .reg_dest  (ctrl_writeReg),
        .reg_data  (data_writeReg)
    );

endmodule

// File: mem_wb_stage.sv
module mem_wb_stage (
    input  logic               clock,
    input  logic               rst_n,
    input  proc_pkg::insn_t    em_insn,
    input  proc_pkg::word_t    em_result,
    input  proc_pkg::word_t    em_addr,
    input  proc_pkg::word_t    em_store,
    input  proc_pkg::word_t    dmem_q,
    bypass_if.producer         byp,
    output proc_pkg::word_t    dmem_addr,
    output proc_pkg::word_t    dmem_data,
    output logic               dmem_wren,
    output logic               reg_we,
    output proc_pkg::reg_idx_t reg_dest,
    output proc_pkg::word_t    reg_data
);
    import proc_pkg::*;

    insn_t mw_insn;
    word_t mw_result;
    word_t mw_load;

    function automatic logic writes_reg(input insn_t insn);
        return insn.r.opcode inside {OP_RTYPE, OP_ADDI, OP_LW, OP_JAL};
    endfunction

    function automatic reg_idx_t dest_of(input insn_t insn);
        return (insn.r.opcode == OP_JAL) ? LINK_REG : insn.i.rd;
    endfunction

    assign dmem_addr = em_addr;
    assign dmem_wren = (em_insn.r.opcode == OP_SW);
    // Store data may still be on its way into the register file
    assign dmem_data = (byp.wb_dest != '0 && byp.wb_dest == em_insn.i.rd) ?
                       byp.wb_value : em_store;

    // Load data is not ready here yet, so loads offer nothing
    assign byp.mem_dest  = (writes_reg(em_insn) && em_insn.r.opcode != OP_LW) ?
                           dest_of(em_insn) : '0;
    assign byp.mem_value = em_result;

    // Memory/writeback register
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mw_insn <= NOP_INSN;
        end else begin
            mw_insn <= em_insn;
        end
    end

    always_ff @(posedge clock) begin
        mw_result <= em_result;
        mw_load   <= dmem_q;
    end

    assign reg_dest = dest_of(mw_insn);
    assign reg_we   = writes_reg(mw_insn) && (reg_dest != '0);   // r0 stays zero
    assign reg_data = (mw_insn.r.opcode == OP_LW) ? mw_load : mw_result;

    assign byp.wb_dest  = reg_we ? reg_dest : '0;
    assign byp.wb_value = reg_data;

endmodule

// File: execute_stage.sv
module execute_stage (
    input  logic               clock,
    input  logic               rst_n,
    input  proc_pkg::insn_t    de_insn,
    input  proc_pkg::word_t    de_pc_plus1,
    input  proc_pkg::word_t    de_a,
    input  proc_pkg::word_t    de_b,
    input  proc_pkg::word_t    de_imm,
    input  proc_pkg::reg_idx_t de_src_a,
    input  proc_pkg::reg_idx_t de_src_b,
    bypass_if.consumer         byp,
    output logic               redirect,
    output proc_pkg::word_t    redirect_pc,
    output proc_pkg::insn_t    em_insn,
    output proc_pkg::word_t    em_result,
    output proc_pkg::word_t    em_addr,
    output proc_pkg::word_t    em_store
);
    import proc_pkg::*;

    opcode_t op;
    alu_op_t alu_op;
    word_t   op_a;
    word_t   op_b;
    word_t   alu_b;
    word_t   alu_result;
    logic    use_imm;
    logic    not_equal;
    logic    less_than;

    assign op = de_insn.r.opcode;

    // Memory stage is younger, so it takes priority
    assign op_a = (de_src_a != '0 && de_src_a == byp.mem_dest) ? byp.mem_value :
                  (de_src_a != '0 && de_src_a == byp.wb_dest)  ? byp.wb_value  : de_a;
    assign op_b = (de_src_b != '0 && de_src_b == byp.mem_dest) ? byp.mem_value :
                  (de_src_b != '0 && de_src_b == byp.wb_dest)  ? byp.wb_value  : de_b;

    always_comb begin
        alu_op  = de_insn.r.aluop;
        use_imm = 1'b0;
        case (op)
            OP_ADDI, OP_LW, OP_SW: begin
                alu_op  = ALU_ADD;
                use_imm = 1'b1;      // Also the load/store address
            end
            OP_BNE, OP_BLT: begin
                alu_op = ALU_SUB;
            end
            default: begin
            end
        endcase
    end

    assign alu_b = use_imm ? de_imm : op_b;

    alu i_alu (
        .a         (op_a),
        .b         (alu_b),
        .op        (alu_op),
        .shamt     (de_insn.r.shamt),
        .result    (alu_result),
        .not_equal (not_equal),
        .less_than (less_than)
    );

    // Control transfer, a is rs and b is rd here
    always_comb begin
        redirect    = 1'b0;
        redirect_pc = de_pc_plus1 + de_imm;
        case (op)
            OP_J, OP_JAL: begin
                redirect    = 1'b1;
                redirect_pc = {{(XLEN-27){1'b0}}, de_insn.ji.target};
            end
            OP_JR: begin
                redirect    = 1'b1;
                redirect_pc = op_b;
            end
            OP_BNE: begin
                redirect = not_equal;
            end
            OP_BLT: begin
                redirect = not_equal && !less_than;  // rd < rs
            end
            default: begin
            end
        endcase
    end

    // Execute/memory register
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            em_insn <= NOP_INSN;
        end else begin
            em_insn <= de_insn;
        end
    end

    always_ff @(posedge clock) begin
        em_result <= (op == OP_JAL) ? de_pc_plus1 : alu_result;  // Link value for jal
        em_addr   <= alu_result;
        em_store  <= op_b;
    end

endmodule

// File: decode_stage.sv
module decode_stage (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               redirect,
    input  proc_pkg::insn_t    fd_insn,
    input  proc_pkg::word_t    fd_pc_plus1,
    input  proc_pkg::word_t    reg_a_data,
    input  proc_pkg::word_t    reg_b_data,
    output proc_pkg::reg_idx_t read_reg_a,
    output proc_pkg::reg_idx_t read_reg_b,
    output logic               stall,
    output proc_pkg::insn_t    de_insn,
    output proc_pkg::word_t    de_pc_plus1,
    output proc_pkg::word_t    de_a,
    output proc_pkg::word_t    de_b,
    output proc_pkg::word_t    de_imm,
    output proc_pkg::reg_idx_t de_src_a,
    output proc_pkg::reg_idx_t de_src_b
);
    import proc_pkg::*;

    opcode_t  op;
    reg_idx_t load_dest;
    logic     reads_rd;
    logic     uses_a;
    logic     uses_b;
    logic     bubble;

    assign op = fd_insn.r.opcode;

    // Branches, jr and sw carry their second source in the rd field
    assign reads_rd   = op inside {OP_BNE, OP_BLT, OP_JR, OP_SW};
    assign read_reg_a = fd_insn.r.rs;
    assign read_reg_b = reads_rd ? fd_insn.r.rd : fd_insn.r.rt;

    // Store data is left out of uses_b, memory stage forwards it from writeback
    assign uses_a = op inside {OP_RTYPE, OP_ADDI, OP_LW, OP_SW, OP_BNE, OP_BLT};
    assign uses_b = op inside {OP_RTYPE, OP_BNE, OP_BLT, OP_JR};

    assign load_dest = de_insn.i.rd;
    assign stall = (de_insn.i.opcode == OP_LW) && (load_dest != '0) &&
                   ((uses_a && load_dest == read_reg_a) ||
                    (uses_b && load_dest == read_reg_b));

    assign bubble = stall || redirect;

    // Decode/execute register, control part
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            de_insn  <= NOP_INSN;
            de_src_a <= '0;
            de_src_b <= '0;
        end else if (bubble) begin
            de_insn  <= NOP_INSN;
            de_src_a <= '0;      // Keeps the bubble out of forwarding
            de_src_b <= '0;
        end else begin
            de_insn  <= fd_insn;
            de_src_a <= read_reg_a;
            de_src_b <= read_reg_b;
        end
    end

    // Operands and immediate
    always_ff @(posedge clock) begin
        de_pc_plus1 <= fd_pc_plus1;
        de_a        <= reg_a_data;
        de_b        <= reg_b_data;
        de_imm      <= {{(XLEN-17){fd_insn.i.imm[16]}}, fd_insn.i.imm};
    end

endmodule

// File: fetch_stage.sv
module fetch_stage #(
    parameter proc_pkg::word_t RESET_PC = '0
) (
    input  logic            clock,
    input  logic            rst_n,
    input  logic            stall,
    input  logic            redirect,
    input  proc_pkg::word_t redirect_pc,
    input  proc_pkg::word_t imem_data,
    output proc_pkg::word_t pc,
    output proc_pkg::word_t fd_pc_plus1,
    output proc_pkg::insn_t fd_insn
);
    import proc_pkg::*;

    word_t pc_plus1;

    assign pc_plus1 = pc + word_t'(1);

    // Redirect wins over a load-use hold
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            pc <= pc_plus1;
        end
    end

    // Fetch/decode register
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            fd_insn <= NOP_INSN;
        end else if (redirect) begin
            fd_insn <= NOP_INSN;          // Squash the wrong-path fetch
        end else if (!stall) begin
            fd_insn <= insn_t'(imem_data);
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            fd_pc_plus1 <= pc_plus1;
        end
    end

endmodule

// File: alu.sv
module alu (
    input  proc_pkg::word_t   a,
    input  proc_pkg::word_t   b,
    input  proc_pkg::alu_op_t op,
    input  logic [4:0]        shamt,
    output proc_pkg::word_t   result,
    output logic              not_equal,
    output logic              less_than
);
    import proc_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_SLL: begin
                result = a << shamt;
            end
            ALU_SRA: begin
                result = word_t'($signed(a) >>> shamt);  // Sign fill
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // Branch flags, signed compare of a against b
    assign not_equal = (a != b);
    assign less_than = ($signed(a) < $signed(b));

endmodule

// File: bypass_if.sv
// Results heading back to execute for operand forwarding
interface bypass_if;
    import proc_pkg::*;

    // Destinations read as zero when the stage writes no register
    reg_idx_t mem_dest;
    word_t    mem_value;
    reg_idx_t wb_dest;     // Same cycle as the register file write
    word_t    wb_value;

    modport producer (
        output mem_dest,
        output mem_value,
        output wb_dest,
        output wb_value
    );

    modport consumer (
        input mem_dest,
        input mem_value,
        input wb_dest,
        input wb_value
    );

endinterface

// File: proc_pkg.sv
package proc_pkg;

    localparam int XLEN  = 32;
    localparam int REG_W = 5;

    typedef logic [XLEN-1:0]  word_t;
    typedef logic [REG_W-1:0] reg_idx_t;

    // Top five bits of every instruction
    typedef enum logic [4:0] {
        OP_RTYPE = 5'b00000,
        OP_J     = 5'b00001,
        OP_BNE   = 5'b00010,
        OP_JAL   = 5'b00011,
        OP_JR    = 5'b00100,
        OP_ADDI  = 5'b00101,
        OP_BLT   = 5'b00110,
        OP_SW    = 5'b00111,
        OP_LW    = 5'b01000
    } opcode_t;

    typedef enum logic [4:0] {
        ALU_ADD = 5'b00000,
        ALU_SUB = 5'b00001,
        ALU_AND = 5'b00010,
        ALU_OR  = 5'b00011,
        ALU_SLL = 5'b00100,
        ALU_SRA = 5'b00101
    } alu_op_t;

    typedef struct packed {
        opcode_t    opcode;
        reg_idx_t   rd;
        reg_idx_t   rs;
        reg_idx_t   rt;
        logic [4:0] shamt;
        alu_op_t    aluop;
        logic [1:0] zero;
    } r_insn_t;

    typedef struct packed {
        opcode_t     opcode;
        reg_idx_t    rd;
        reg_idx_t    rs;
        logic [16:0] imm;   // Sign extended in decode
    } i_insn_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [26:0] target;
    } ji_insn_t;

    // One instruction word, three field layouts
    typedef union packed {
        r_insn_t  r;
        i_insn_t  i;
        ji_insn_t ji;
    } insn_t;

    localparam insn_t    NOP_INSN = '0;   // add r0, r0, r0
    localparam reg_idx_t LINK_REG = 5'd31;

endpackage
